//--- pd_macros.svh
// Trigger delay unit parameters.
// Channel count and the widths of delay, channel index and timestamp.
`ifndef PD_MACROS_SVH
`define PD_MACROS_SVH

// four peer channels share one event stream.
`define PD_NUM_CHANNELS 4

`define PD_DELAY_BITS 8
`define PD_CHAN_BITS 2

// timestamp wraps modulo 2^16.
`define PD_STAMP_BITS 16

`endif

//--- pd_pkg.sv
// Trigger delay unit types.
// Width typedefs, the configuration write and event record structs, the timer states.
`include "pd_macros.svh"

package pd_pkg;

  typedef logic [`PD_DELAY_BITS-1:0] delay_t;   // delay in cycles.
  typedef logic [`PD_CHAN_BITS-1:0]  chan_id_t; // channel index.
  typedef logic [`PD_STAMP_BITS-1:0] stamp_t;   // free-running cycle stamp.

  // one configuration register write.
  typedef struct packed {
    chan_id_t chan;
    delay_t   delay;
  } cfg_wr_t;

  // one fired pulse as seen on the event stream.
  typedef struct packed {
    chan_id_t chan;
    stamp_t   stamp;
  } event_rec_t;

  typedef enum logic {PD_IDLE, PD_WAIT} pd_state_t;

endpackage

//--- pulse_delay.sv
// Retriggerable delay timer.
// Emits one registered pulse delay+1 cycles after the last accepted trigger.
`timescale 1ns/1ps

module pulse_delay import pd_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  delay_t delay,
  input  logic   in_pls,
  output logic   out_pls
);

  pd_state_t state;
  delay_t    count;

  logic expire;

  assign expire = (state == PD_WAIT) && (count == delay_t'(1)); // last waiting cycle.

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= PD_IDLE;
      count   <= '0;
      out_pls <= 1'b0;
    end else begin
      if (in_pls) begin
        // a new trigger always replaces the pending schedule.
        count   <= delay;
        out_pls <= (delay == '0);
        state   <= (delay == '0) ? PD_IDLE : PD_WAIT;
      end else if (state == PD_WAIT) begin
        count   <= count - delay_t'(1);
        out_pls <= expire;
        if (expire) begin
          state <= PD_IDLE;
        end
      end else begin
        out_pls <= 1'b0;
      end
    end
  end

endmodule

//--- delay_channel.sv
// One trigger delay channel.
// Timer, stamp capture into a one-entry record register and a sticky drop flag.
`timescale 1ns/1ps

module delay_channel import pd_pkg::*; #(
  parameter int chan_index = 0
) (
  input  logic       clk,
  input  logic       rst,
  input  delay_t     delay,
  input  stamp_t     stamp,
  input  logic       trig,
  output logic       pls,
  output logic       rec_valid,
  output event_rec_t rec,
  input  logic       rec_grant,
  output logic       drop
);

  stamp_t rec_stamp;
  logic   taken;
  logic   capture;

  pulse_delay u_timer (
    .clk     (clk),
    .rst     (rst),
    .delay   (delay),
    .in_pls  (trig),
    .out_pls (pls)
  );

  assign taken   = rec_valid && rec_grant;        // record leaves this cycle.
  assign capture = pls && (!rec_valid || taken);  // room for the new record.

  always_ff @(posedge clk) begin
    if (rst) begin
      rec_valid <= 1'b0;
      drop      <= 1'b0;
    end else begin
      if (capture) begin
        rec_valid <= 1'b1;
      end else if (taken) begin
        rec_valid <= 1'b0;
      end
      // holding register still full, so this firing is lost
      if (pls && !capture) begin
        drop <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      rec_stamp <= stamp;
    end
  end

  assign rec.chan  = chan_id_t'(chan_index);
  assign rec.stamp = rec_stamp;

endmodule

//--- trigger_ctrl.sv
// Trigger delay control block.
// Per-channel delay registers from configuration writes, and the shared timestamp counter.
`timescale 1ns/1ps
`include "pd_macros.svh"

module trigger_ctrl import pd_pkg::*; (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              cfg_valid,
  input  cfg_wr_t                           cfg,
  output delay_t [`PD_NUM_CHANNELS-1:0]     delays,
  output stamp_t                            stamp
);

  // writes land at the edge and are seen from the next cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      delays <= '0;
    end else begin
      for (int c = 0; c < `PD_NUM_CHANNELS; c++) begin
        if (cfg_valid && (cfg.chan == chan_id_t'(c))) begin
          delays[c] <= cfg.delay;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stamp <= '0;
    end else begin
      stamp <= stamp + stamp_t'(1); // wraps naturally.
    end
  end

endmodule

//--- event_arbiter.sv
// Round-robin event arbiter.
// Merges channel records into one registered valid/ready event stream.
`timescale 1ns/1ps
`include "pd_macros.svh"

module event_arbiter import pd_pkg::*; (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [`PD_NUM_CHANNELS-1:0]           rec_valid,
  input  event_rec_t [`PD_NUM_CHANNELS-1:0]     rec,
  output logic [`PD_NUM_CHANNELS-1:0]           rec_grant,
  output logic                                  ev_valid,
  output event_rec_t                            ev,
  input  logic                                  ev_ready
);

  localparam int NUM = `PD_NUM_CHANNELS;

  chan_id_t           ptr;       // highest priority channel.
  chan_id_t           grant_idx;
  logic               grant_any;
  logic [NUM-1:0]     grant_vec;
  logic               load_ok;

  assign load_ok = !ev_valid || ev_ready; // output empty or emptying.

  // first requester at or after the pointer
  always_comb begin
    int idx;
    grant_vec = '0;
    grant_idx = '0;
    grant_any = 1'b0;
    for (int i = 0; i < NUM; i++) begin
      idx = (int'(ptr) + i) % NUM;
      if (!grant_any && rec_valid[idx]) begin
        grant_vec[idx] = 1'b1;
        grant_idx      = chan_id_t'(idx);
        grant_any      = 1'b1;
      end
    end
  end

  assign rec_grant = load_ok ? grant_vec : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      ev_valid <= 1'b0;
      ptr      <= '0;
    end else if (load_ok) begin
      ev_valid <= grant_any;
      if (grant_any) begin
        ptr <= (int'(grant_idx) == NUM - 1) ? chan_id_t'(0) : grant_idx + chan_id_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_ok && grant_any) begin
      ev <= rec[grant_idx];
    end
  end

endmodule

//--- pulse_delay_top.sv
// Multi-channel trigger delay unit.
// Control block, one delay channel per trigger input, and the event arbiter.
`timescale 1ns/1ps
`include "pd_macros.svh"

module pulse_delay_top import pd_pkg::*; (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          cfg_valid,
  input  cfg_wr_t                       cfg,
  input  logic [`PD_NUM_CHANNELS-1:0]   trig,
  output logic [`PD_NUM_CHANNELS-1:0]   pls,
  output logic [`PD_NUM_CHANNELS-1:0]   drop,
  output logic                          ev_valid,
  output event_rec_t                    ev,
  input  logic                          ev_ready
);

  delay_t [`PD_NUM_CHANNELS-1:0]     delays;
  stamp_t                            stamp;
  logic [`PD_NUM_CHANNELS-1:0]       rec_valid;
  event_rec_t [`PD_NUM_CHANNELS-1:0] rec;
  logic [`PD_NUM_CHANNELS-1:0]       rec_grant;

  trigger_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .cfg_valid (cfg_valid),
    .cfg       (cfg),
    .delays    (delays),
    .stamp     (stamp)
  );

  for (genvar c = 0; c < `PD_NUM_CHANNELS; c++) begin : g_chan
    delay_channel #(
      .chan_index (c)
    ) u_chan (
      .clk       (clk),
      .rst       (rst),
      .delay     (delays[c]),
      .stamp     (stamp),
      .trig      (trig[c]),
      .pls       (pls[c]),
      .rec_valid (rec_valid[c]),
      .rec       (rec[c]),
      .rec_grant (rec_grant[c]),
      .drop      (drop[c])
    );
  end

  event_arbiter u_arb (
    .clk       (clk),
    .rst       (rst),
    .rec_valid (rec_valid),
    .rec       (rec),
    .rec_grant (rec_grant),
    .ev_valid  (ev_valid),
    .ev        (ev),
    .ev_ready  (ev_ready)
  );

endmodule

//--- pulse_delay_sva.sv
// Port assertions for the trigger delay unit.
// Event hold under back-pressure, sticky drop flags and isolated pulses.
`timescale 1ns/1ps
`include "pd_macros.svh"

module pulse_delay_sva import pd_pkg::*; (
  input logic                                clk,
  input logic                                rst,
  input logic [`PD_NUM_CHANNELS-1:0]         trig,
  input logic [`PD_NUM_CHANNELS-1:0]         pls,
  input logic [`PD_NUM_CHANNELS-1:0]         drop,
  input delay_t [`PD_NUM_CHANNELS-1:0]       delays,
  input logic                                ev_valid,
  input event_rec_t                          ev,
  input logic                                ev_ready
);

  // a stalled event keeps its content.
  ev_hold: assert property (@(posedge clk) disable iff (rst)
    ev_valid && !ev_ready |=> ev_valid && $stable(ev))
    else $error("event record changed while stalled");

  for (genvar c = 0; c < `PD_NUM_CHANNELS; c++) begin : g_chk
    drop_sticky: assert property (@(posedge clk) disable iff (rst)
      $past(drop[c]) |-> drop[c])
      else $error("drop flag of channel %0d fell", c);

    // back-to-back pulses only from a zero delay retrigger.
    pls_single: assert property (@(posedge clk) disable iff (rst)
      pls[c] && $past(pls[c]) |-> $past(trig[c]) && ($past(delays[c]) == '0))
      else $error("channel %0d pulsed two cycles in a row", c);
  end

endmodule

bind pulse_delay_top pulse_delay_sva u_sva (
  .clk      (clk),
  .rst      (rst),
  .trig     (trig),
  .pls      (pls),
  .drop     (drop),
  .delays   (delays),
  .ev_valid (ev_valid),
  .ev       (ev),
  .ev_ready (ev_ready)
);

//--- tb_pulse_delay.sv
// Testbench for the multi-channel trigger delay unit.
// Directed and random triggers checked against a cycle-level reference model.
`timescale 1ns/1ps
`include "pd_macros.svh"

module tb_pulse_delay import pd_pkg::*; ();

  localparam int NCH            = `PD_NUM_CHANNELS;
  localparam int RAND_STEPS     = 400;
  localparam int DIRECTED_TRIGS = 20;
  localparam int MAX_DELAY      = 15;
  localparam int CYCLE_LIMIT    = (RAND_STEPS + DIRECTED_TRIGS) * (MAX_DELAY + 1) + 1000;

  logic           clk;
  logic           rst;
  logic           cfg_valid;
  cfg_wr_t        cfg;
  logic [NCH-1:0] trig;
  logic [NCH-1:0] pls;
  logic [NCH-1:0] drop;
  logic           ev_valid;
  event_rec_t     ev;
  logic           ev_ready;

  int             cyc = 0;
  int             rel_cyc = 0;
  int             errors = 0;
  int             pend[NCH][$];      // expected firing cycles.
  stamp_t         exp_stamp[NCH][$]; // records still to arrive.
  delay_t         cur_delay[NCH];
  logic [NCH-1:0] exp_drop;
  logic [NCH-1:0] lose_record;       // next firing finds the holding register full.
  logic [31:0]    rng;
  int             ready_mode;        // 0 high, 1 low, 2 random.
  logic           checking;
  string          test_name;

  pulse_delay_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .cfg_valid (cfg_valid),
    .cfg       (cfg),
    .trig      (trig),
    .pls       (pls),
    .drop      (drop),
    .ev_valid  (ev_valid),
    .ev        (ev),
    .ev_ready  (ev_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("errors: %0d", errors);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // timer rule: trigger in cycle t fires in cycle t+d+1.
  function automatic int fire_cycle(input int trig_cyc, input delay_t d);
    return trig_cyc + int'(d) + 1;
  endfunction

  function automatic int pending_total();
    int n;
    n = 0;
    for (int c = 0; c < NCH; c++) n += pend[c].size();
    return n;
  endfunction

  function automatic int record_total();
    int n;
    n = 0;
    for (int c = 0; c < NCH; c++) n += exp_stamp[c].size();
    return n;
  endfunction

  // no record outstanding and nothing firing up to the trigger's cycle.
  function automatic logic may_fire(input int c);
    return (exp_stamp[c].size() == 0) && ((pend[c].size() == 0) || (pend[c][0] > cyc + 1));
  endfunction

  task automatic step(input logic [NCH-1:0] mask, input logic wr, input chan_id_t wr_chan,
                      input delay_t wr_delay);
    @(posedge clk);
    #1;
    trig      = mask;
    cfg_valid = wr;
    cfg.chan  = wr_chan;
    cfg.delay = wr_delay;
    for (int c = 0; c < NCH; c++) begin
      if (mask[c]) begin
        while ((pend[c].size() > 0) && (pend[c][$] > cyc)) void'(pend[c].pop_back());
        pend[c].push_back(fire_cycle(cyc, cur_delay[c]));
      end
    end
    if (wr) cur_delay[wr_chan] = wr_delay; // seen by triggers from the next cycle.
    case (ready_mode)
      0: ev_ready = 1'b1;
      1: ev_ready = 1'b0;
      default: begin
        rng      = xorshift(rng);
        ev_ready = (rng[7:4] > 4'd4);
      end
    endcase
  endtask

  task automatic idle(input int n);
    repeat (n) step('0, 1'b0, '0, '0);
  endtask

  task automatic write_delay(input int c, input int d);
    step('0, 1'b1, chan_id_t'(c), delay_t'(d));
  endtask

  task automatic fire(input logic [NCH-1:0] mask);
    step(mask, 1'b0, '0, '0);
  endtask

  task automatic wait_fired();
    while (pending_total() != 0) idle(1);
  endtask

  task automatic drain();
    while ((pending_total() != 0) || (record_total() != 0) || ev_valid) idle(1);
    idle(2);
  endtask

  always @(negedge clk) begin : compare
    logic hit;
    int   ch;
    if (checking) begin
      if (drop !== exp_drop) begin
        errors++;
        $display("** Error [%s] drop expected %b actual %b", test_name, exp_drop, drop);
      end
      for (int c = 0; c < NCH; c++) begin
        hit = (pend[c].size() > 0) && (pend[c][0] == cyc);
        if (hit) void'(pend[c].pop_front());
        if (pls[c] !== hit) begin
          errors++;
          $display("** Error [%s] pls[%0d] cycle %0d expected %b actual %b",
                   test_name, c, cyc - rel_cyc, hit, pls[c]);
        end
        if (hit) begin
          if (lose_record[c]) begin
            lose_record[c] = 1'b0;
            exp_drop[c]    = 1'b1;
          end else begin
            exp_stamp[c].push_back(stamp_t'(cyc - rel_cyc));
          end
        end
      end
      if (ev_valid && ev_ready) begin
        ch = int'(ev.chan);
        if (exp_stamp[ch].size() == 0) begin
          errors++;
          $display("unexpected event record from channel %0d with stamp %0d in %s",
                   ch, ev.stamp, test_name);
        end else begin
          if (ev.stamp !== exp_stamp[ch][0]) begin
            errors++;
            $display("** Error [%s] ev stamp on channel %0d expected %0d actual %0d",
                     test_name, ch, exp_stamp[ch][0], ev.stamp);
          end
          void'(exp_stamp[ch].pop_front());
        end
      end
    end
  end

  initial begin : main
    logic [NCH-1:0] one_hot;
    int             c_pick;
    rst         = 1'b1;
    cfg_valid   = 1'b0;
    cfg         = '0;
    trig        = '0;
    ev_ready    = 1'b1;
    rng         = 32'd11411;
    ready_mode  = 0;
    checking    = 1'b0;
    exp_drop    = '0;
    lose_record = '0;
    test_name   = "reset";
    for (int c = 0; c < NCH; c++) cur_delay[c] = '0;
    repeat (2) @(posedge clk);
    #1;
    rst      = 1'b0;
    rel_cyc  = cyc;  // stamp counts from this cycle.
    checking = 1'b1;

    test_name = "fixed_delay";
    write_delay(0, 1);
    write_delay(1, 3);
    write_delay(2, 5);
    write_delay(3, 0);
    for (int c = 0; c < NCH; c++) begin
      one_hot    = '0;
      one_hot[c] = 1'b1;
      fire(one_hot);
      wait_fired();
      idle(2);
    end
    drain();

    test_name = "retrigger";
    write_delay(2, 6);
    fire(4'b0100);
    idle(2);
    fire(4'b0100);   // replaces the pending pulse.
    drain();

    test_name = "delay_change";
    write_delay(0, 4);
    fire(4'b0001);
    write_delay(0, 9); // pulse in flight keeps delay 4.
    wait_fired();
    fire(4'b0001);
    drain();

    test_name = "contention";
    for (int c = 0; c < NCH; c++) write_delay(c, 3);
    fire(4'b1111);
    drain();

    test_name = "backpressure";
    write_delay(1, 2);
    ready_mode = 1;
    fire(4'b0010);   // ends up in the arbiter.
    wait_fired();
    idle(3);
    fire(4'b0010);   // held by the channel.
    wait_fired();
    idle(3);
    lose_record[1] = 1'b1;
    fire(4'b0010);
    wait_fired();
    idle(3);
    ready_mode = 0;
    drain();

    test_name  = "random";
    ready_mode = 2;
    for (int i = 0; i < RAND_STEPS; i++) begin
      rng    = xorshift(rng);
      c_pick = int'(rng[9:8]);
      if (rng[2:0] == 3'd0) begin
        write_delay(c_pick, int'(rng[13:10]));
      end else if ((rng[4:3] == 2'b11) && may_fire(c_pick)) begin
        one_hot         = '0;
        one_hot[c_pick] = 1'b1;
        fire(one_hot);
      end else begin
        idle(1);
      end
    end
    ready_mode = 0;
    drain();

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+.
pd_pkg.sv
pulse_delay.sv
delay_channel.sv
trigger_ctrl.sv
event_arbiter.sv
pulse_delay_top.sv
pulse_delay_sva.sv
tb_pulse_delay.sv

//--- run.sh
#!/bin/sh
# Builds the trigger delay unit testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_pulse_delay -f vlog.f -o tb_pulse_delay
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_pulse_delay > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Verification passed" sim.log; then
  exit 0
fi

echo "pass message not found in sim.log"
exit 1
